/* logic/ooo_cfg.svh */
`ifndef OOO_CFG_SVH
`define OOO_CFG_SVH

// register counts
`define OOO_ARCH_REGS 8
`define OOO_PHYS_REGS 16

// queue depths
`define OOO_ROB_DEPTH 8
`define OOO_IQ_DEPTH  4

// execution resources
`define OOO_NUM_ALU   2

// operand and result width
`define OOO_DATA_W    32

`endif

/* logic/ooo_pkg.sv */
`default_nettype none
`include "ooo_cfg.svh"

package ooo_pkg;

    typedef logic [`OOO_DATA_W-1:0]             data_t;
    typedef logic [$clog2(`OOO_ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [$clog2(`OOO_PHYS_REGS)-1:0] phys_reg_t;
    typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0] rob_idx_t;

    // slt is a signed compare
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT
    } alu_op_e;

    typedef struct packed {
        alu_op_e   op;
        arch_reg_t src1;
        arch_reg_t src2;
        arch_reg_t dst;
        data_t     imm;
        logic      use_imm;
    } dispatch_t;

    typedef struct packed {
        alu_op_e   op;
        phys_reg_t psrc1;
        phys_reg_t psrc2;
        phys_reg_t pdst;
        data_t     imm;
        logic      use_imm;
        rob_idx_t  rob_idx;
    } iq_entry_t;

    typedef struct packed {
        logic      valid;
        alu_op_e   op;
        data_t     a;
        data_t     b;
        phys_reg_t pdst;
        rob_idx_t  rob_idx;
    } alu_req_t;

    typedef struct packed {
        logic      valid;
        phys_reg_t pdst;
        data_t     value;
        rob_idx_t  rob_idx;
    } wb_t;

    typedef struct packed {
        arch_reg_t dst;
        data_t     value;
    } retire_t;

endpackage

`default_nettype wire

/* logic/rename_unit.sv */
`timescale 1ns/10ps
`default_nettype none
`include "ooo_cfg.svh"

module rename_unit (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire logic                alloc,
    input  wire ooo_pkg::dispatch_t  dispatch,
    input  wire logic                free_valid,
    input  wire ooo_pkg::phys_reg_t  free_tag,
    output ooo_pkg::phys_reg_t       psrc1,
    output ooo_pkg::phys_reg_t       psrc2,
    output ooo_pkg::phys_reg_t       pdst,
    output ooo_pkg::phys_reg_t       old_pdst
);

    // tags not mapped by the alias table
    localparam int FL_DEPTH = `OOO_PHYS_REGS - `OOO_ARCH_REGS;
    localparam int FL_AW    = $clog2(FL_DEPTH);

    ooo_pkg::phys_reg_t rat [`OOO_ARCH_REGS];
    ooo_pkg::phys_reg_t free_list [FL_DEPTH];
    logic [FL_AW-1:0]   fl_head;
    logic [FL_AW-1:0]   fl_tail;
    logic [FL_AW:0]     fl_count;

    assign psrc1    = rat[dispatch.src1];
    assign psrc2    = rat[dispatch.src2];
    assign old_pdst = rat[dispatch.dst];
    assign pdst     = free_list[fl_head];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < `OOO_ARCH_REGS; r++) begin
                rat[r] <= ooo_pkg::phys_reg_t'(r);
            end
            for (int i = 0; i < FL_DEPTH; i++) begin
                free_list[i] <= ooo_pkg::phys_reg_t'(`OOO_ARCH_REGS + i);
            end
            fl_head  <= '0;
            fl_tail  <= '0;
            fl_count <= (FL_AW + 1)'(FL_DEPTH);
        end else begin
            if (alloc) begin
                rat[dispatch.dst] <= pdst;
                fl_head           <= fl_head + 1'b1;
            end
            // old mapping comes back at retire
            if (free_valid) begin
                free_list[fl_tail] <= free_tag;
                fl_tail            <= fl_tail + 1'b1;
            end
            case ({alloc, free_valid})
                2'b10:   fl_count <= fl_count - 1'b1;
                2'b01:   fl_count <= fl_count + 1'b1;
                default: fl_count <= fl_count;
            endcase
        end
    end

    // rob occupancy must keep a tag in reserve
    a_no_empty_alloc: assert property (@(posedge clk) disable iff (!arst_n)
        alloc |-> fl_count != '0);

endmodule

`default_nettype wire

/* logic/phys_reg_file.sv */
`timescale 1ns/10ps
`default_nettype none
`include "ooo_cfg.svh"

module phys_reg_file (
    input  wire logic                 clk,
    input  wire logic                 arst_n,
    input  wire logic                 alloc,
    input  wire ooo_pkg::phys_reg_t   alloc_tag,
    input  wire ooo_pkg::iq_entry_t   issue [`OOO_NUM_ALU],
    input  wire ooo_pkg::wb_t         wb [`OOO_NUM_ALU],
    input  wire ooo_pkg::phys_reg_t   retire_tag,
    output logic [`OOO_PHYS_REGS-1:0] ready_bits,
    output ooo_pkg::data_t            src1_value [`OOO_NUM_ALU],
    output ooo_pkg::data_t            src2_value [`OOO_NUM_ALU],
    output ooo_pkg::data_t            retire_value
);

    ooo_pkg::data_t regs [`OOO_PHYS_REGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ready_bits <= '1;
            for (int i = 0; i < `OOO_PHYS_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // new destination waits for its producer
            if (alloc) begin
                ready_bits[alloc_tag] <= 1'b0;
            end
            for (int k = 0; k < `OOO_NUM_ALU; k++) begin
                if (wb[k].valid) begin
                    regs[wb[k].pdst]       <= wb[k].value;
                    ready_bits[wb[k].pdst] <= 1'b1;
                end
            end
        end
    end

    // operand read in the issue cycle
    always_comb begin
        for (int k = 0; k < `OOO_NUM_ALU; k++) begin
            src1_value[k] = regs[issue[k].psrc1];
            src2_value[k] = regs[issue[k].psrc2];
        end
    end

    assign retire_value = regs[retire_tag];

    for (genvar i = 0; i < `OOO_NUM_ALU; i++) begin : g_wb_i
        for (genvar j = i + 1; j < `OOO_NUM_ALU; j++) begin : g_wb_j
            a_wb_unique: assert property (@(posedge clk) disable iff (!arst_n)
                wb[i].valid && wb[j].valid |-> wb[i].pdst != wb[j].pdst);
        end
    end

endmodule

`default_nettype wire

/* logic/issue_queue.sv */
`timescale 1ns/10ps
`default_nettype none
`include "ooo_cfg.svh"

module issue_queue (
    input  wire logic                     clk,
    input  wire logic                     arst_n,
    input  wire logic                     push,
    input  wire ooo_pkg::iq_entry_t       entry,
    input  wire [`OOO_PHYS_REGS-1:0]      ready_bits,
    output logic                          full,
    output ooo_pkg::iq_entry_t            issue [`OOO_NUM_ALU],
    output logic [`OOO_NUM_ALU-1:0]       issue_valid
);

    localparam int SLOT_W = $clog2(`OOO_IQ_DEPTH);

    ooo_pkg::iq_entry_t        slots [`OOO_IQ_DEPTH];
    logic [`OOO_IQ_DEPTH-1:0]  valid;
    logic [`OOO_IQ_DEPTH-1:0]  req;
    logic [`OOO_IQ_DEPTH-1:0]  avail;
    logic [SLOT_W-1:0]         issue_slot [`OOO_NUM_ALU];
    logic [SLOT_W-1:0]         push_slot;

    assign full = &valid;

    // wakeup
    always_comb begin
        for (int i = 0; i < `OOO_IQ_DEPTH; i++) begin
            req[i] = valid[i] && ready_bits[slots[i].psrc1] && ready_bits[slots[i].psrc2];
        end
    end

    // one pick per alu, lowest slot first
    always_comb begin
        avail = req;
        for (int k = 0; k < `OOO_NUM_ALU; k++) begin
            issue_valid[k] = 1'b0;
            issue_slot[k]  = '0;
            for (int i = `OOO_IQ_DEPTH - 1; i >= 0; i--) begin
                if (avail[i]) begin
                    issue_valid[k] = 1'b1;
                    issue_slot[k]  = SLOT_W'(i);
                end
            end
            if (issue_valid[k]) begin
                avail[issue_slot[k]] = 1'b0;
            end
            issue[k] = slots[issue_slot[k]];
        end
    end

    always_comb begin
        push_slot = '0;
        for (int i = `OOO_IQ_DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                push_slot = SLOT_W'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= '0;
        end else begin
            for (int k = 0; k < `OOO_NUM_ALU; k++) begin
                if (issue_valid[k]) begin
                    valid[issue_slot[k]] <= 1'b0;
                end
            end
            if (push) begin
                valid[push_slot] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            slots[push_slot] <= entry;
        end
    end

    // a selected source has no producer still waiting in the queue
    for (genvar k = 0; k < `OOO_NUM_ALU; k++) begin : g_chk
        for (genvar j = 0; j < `OOO_IQ_DEPTH; j++) begin : g_slot
            a_issue_ready: assert property (@(posedge clk) disable iff (!arst_n)
                issue_valid[k] && valid[j]
                    |-> slots[j].pdst != issue[k].psrc1 && slots[j].pdst != issue[k].psrc2);
        end
    end

endmodule

`default_nettype wire

/* logic/alu_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_unit (
    input  wire logic               clk,
    input  wire logic               arst_n,
    input  wire ooo_pkg::alu_req_t  req,
    output ooo_pkg::wb_t            wb
);

    ooo_pkg::data_t     result;
    logic               valid_q;
    ooo_pkg::data_t     value_q;
    ooo_pkg::phys_reg_t pdst_q;
    ooo_pkg::rob_idx_t  rob_idx_q;

    always_comb begin
        case (req.op)
            ooo_pkg::ALU_ADD: result = req.a + req.b;
            ooo_pkg::ALU_SUB: result = req.a - req.b;
            ooo_pkg::ALU_AND: result = req.a & req.b;
            ooo_pkg::ALU_OR:  result = req.a | req.b;
            ooo_pkg::ALU_XOR: result = req.a ^ req.b;
            ooo_pkg::ALU_SLL: result = req.a << req.b[4:0];
            ooo_pkg::ALU_SRL: result = req.a >> req.b[4:0];
            ooo_pkg::ALU_SLT: result = ooo_pkg::data_t'($signed(req.a) < $signed(req.b));
            default:          result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req.valid) begin
            value_q   <= result;
            pdst_q    <= req.pdst;
            rob_idx_q <= req.rob_idx;
        end
    end

    assign wb = '{valid: valid_q, pdst: pdst_q, value: value_q, rob_idx: rob_idx_q};

endmodule

`default_nettype wire

/* logic/reorder_buffer.sv */
`timescale 1ns/10ps
`default_nettype none
`include "ooo_cfg.svh"

module reorder_buffer (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire logic                alloc,
    input  wire ooo_pkg::arch_reg_t  dst,
    input  wire ooo_pkg::phys_reg_t  pdst,
    input  wire ooo_pkg::phys_reg_t  old_pdst,
    input  wire ooo_pkg::wb_t        wb [`OOO_NUM_ALU],
    input  wire ooo_pkg::data_t      retire_value,
    output logic                     full,
    output ooo_pkg::rob_idx_t        tail,
    output ooo_pkg::phys_reg_t       retire_tag,
    output logic                     free_valid,
    output ooo_pkg::phys_reg_t       free_tag,
    output logic                     retire_valid,
    output ooo_pkg::retire_t         retire
);

    localparam int CNT_W = $clog2(`OOO_ROB_DEPTH) + 1;

    ooo_pkg::arch_reg_t        dst_q [`OOO_ROB_DEPTH];
    ooo_pkg::phys_reg_t        pdst_q [`OOO_ROB_DEPTH];
    ooo_pkg::phys_reg_t        old_q [`OOO_ROB_DEPTH];
    logic [`OOO_ROB_DEPTH-1:0] done;
    ooo_pkg::rob_idx_t         head;
    logic [CNT_W-1:0]          count;

    assign full         = count == CNT_W'(`OOO_ROB_DEPTH);
    assign retire_valid = (count != '0) && done[head];
    assign retire_tag   = pdst_q[head];
    assign free_valid   = retire_valid;
    assign free_tag     = old_q[head];
    assign retire       = '{dst: dst_q[head], value: retire_value};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            if (alloc) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            for (int k = 0; k < `OOO_NUM_ALU; k++) begin
                if (wb[k].valid) begin
                    done[wb[k].rob_idx] <= 1'b1;
                end
            end
            if (retire_valid) begin
                head <= head + 1'b1;
            end
            case ({alloc, retire_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            dst_q[tail]  <= dst;
            pdst_q[tail] <= pdst;
            old_q[tail]  <= old_pdst;
        end
    end

    a_no_alloc_full: assert property (@(posedge clk) disable iff (!arst_n)
        alloc |-> !full);

endmodule

`default_nettype wire

/* logic/ooo_core.sv */
`timescale 1ns/10ps
`default_nettype none
`include "ooo_cfg.svh"

module ooo_core (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire ooo_pkg::dispatch_t  dispatch,
    input  wire logic                dispatch_valid,
    output logic                     dispatch_ready,
    output ooo_pkg::retire_t         retire,
    output logic                     retire_valid
);

    logic                      alloc;
    logic                      rob_full;
    logic                      iq_full;
    logic                      free_valid;
    ooo_pkg::phys_reg_t        psrc1;
    ooo_pkg::phys_reg_t        psrc2;
    ooo_pkg::phys_reg_t        pdst;
    ooo_pkg::phys_reg_t        old_pdst;
    ooo_pkg::phys_reg_t        free_tag;
    ooo_pkg::phys_reg_t        retire_tag;
    ooo_pkg::rob_idx_t         rob_tail;
    ooo_pkg::iq_entry_t        iq_entry;
    ooo_pkg::iq_entry_t        issue [`OOO_NUM_ALU];
    logic [`OOO_NUM_ALU-1:0]   issue_valid;
    logic [`OOO_PHYS_REGS-1:0] ready_bits;
    ooo_pkg::data_t            src1_value [`OOO_NUM_ALU];
    ooo_pkg::data_t            src2_value [`OOO_NUM_ALU];
    ooo_pkg::data_t            retire_value;
    ooo_pkg::alu_req_t         alu_req [`OOO_NUM_ALU];
    ooo_pkg::wb_t              wb [`OOO_NUM_ALU];

    // free list never runs dry while the rob has room
    assign dispatch_ready = !rob_full && !iq_full;
    assign alloc          = dispatch_valid && dispatch_ready;

    assign iq_entry = '{op: dispatch.op, psrc1: psrc1, psrc2: psrc2, pdst: pdst,
                        imm: dispatch.imm, use_imm: dispatch.use_imm, rob_idx: rob_tail};

    rename_unit rename_unit_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .alloc      (alloc),
        .dispatch   (dispatch),
        .free_valid (free_valid),
        .free_tag   (free_tag),
        .psrc1      (psrc1),
        .psrc2      (psrc2),
        .pdst       (pdst),
        .old_pdst   (old_pdst)
    );

    phys_reg_file phys_reg_file_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .alloc        (alloc),
        .alloc_tag    (pdst),
        .issue        (issue),
        .wb           (wb),
        .retire_tag   (retire_tag),
        .ready_bits   (ready_bits),
        .src1_value   (src1_value),
        .src2_value   (src2_value),
        .retire_value (retire_value)
    );

    issue_queue issue_queue_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .push        (alloc),
        .entry       (iq_entry),
        .ready_bits  (ready_bits),
        .full        (iq_full),
        .issue       (issue),
        .issue_valid (issue_valid)
    );

    for (genvar k = 0; k < `OOO_NUM_ALU; k++) begin : g_alu
        // immediate replaces the second register operand
        assign alu_req[k] = '{valid: issue_valid[k], op: issue[k].op, a: src1_value[k],
                              b: issue[k].use_imm ? issue[k].imm : src2_value[k],
                              pdst: issue[k].pdst, rob_idx: issue[k].rob_idx};

        alu_unit alu_unit_inst (
            .clk    (clk),
            .arst_n (arst_n),
            .req    (alu_req[k]),
            .wb     (wb[k])
        );
    end

    reorder_buffer reorder_buffer_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .alloc        (alloc),
        .dst          (dispatch.dst),
        .pdst         (pdst),
        .old_pdst     (old_pdst),
        .wb           (wb),
        .retire_value (retire_value),
        .full         (rob_full),
        .tail         (rob_tail),
        .retire_tag   (retire_tag),
        .free_valid   (free_valid),
        .free_tag     (free_tag),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

`default_nettype wire

/* verification/ooo_core_tb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "ooo_cfg.svh"

module ooo_core_tb;

    localparam int SEED_OPS      = `OOO_ARCH_REGS;
    localparam int OPCODE_OPS    = 16;
    localparam int DENSE_OPS     = 150;
    localparam int BURSTS        = 4;
    localparam int BURST_LEN     = 25;
    localparam int LONG_OPS      = 500;
    localparam int TOTAL_OPS     = SEED_OPS + OPCODE_OPS + DENSE_OPS + BURSTS * BURST_LEN
                                   + LONG_OPS;
    localparam int WATCHDOG_CYCS = TOTAL_OPS * 20 + 100;

    logic                 clk;
    logic                 arst_n;
    ooo_pkg::dispatch_t   dispatch;
    logic                 dispatch_valid;
    logic                 dispatch_ready;
    ooo_pkg::retire_t     retire;
    logic                 retire_valid;

    ooo_pkg::data_t       arch_regs [`OOO_ARCH_REGS];
    ooo_pkg::retire_t     pending [$];
    ooo_pkg::retire_t     expected;
    int                   accepted;
    int                   retired;
    bit                   stall_seen;

    ooo_core ooo_core_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .dispatch       (dispatch),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .retire         (retire),
        .retire_valid   (retire_valid)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // architectural result of one operation
    function automatic ooo_pkg::data_t alu_model(input ooo_pkg::alu_op_e op,
                                                 input ooo_pkg::data_t a,
                                                 input ooo_pkg::data_t b);
        case (op)
            ooo_pkg::ALU_ADD: return a + b;
            ooo_pkg::ALU_SUB: return a - b;
            ooo_pkg::ALU_AND: return a & b;
            ooo_pkg::ALU_OR:  return a | b;
            ooo_pkg::ALU_XOR: return a ^ b;
            ooo_pkg::ALU_SLL: return a << b[4:0];
            ooo_pkg::ALU_SRL: return a >> b[4:0];
            default:          return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    // program-order execution of an accepted op
    task automatic model_dispatch(input ooo_pkg::dispatch_t op);
        ooo_pkg::data_t   b;
        ooo_pkg::data_t   value;
        ooo_pkg::retire_t item;
        b     = op.use_imm ? op.imm : arch_regs[op.src2];
        value = alu_model(op.op, arch_regs[op.src1], b);
        arch_regs[op.dst] = value;
        item.dst   = op.dst;
        item.value = value;
        pending.push_back(item);
    endtask

    function automatic ooo_pkg::dispatch_t random_op(input int reg_span);
        ooo_pkg::dispatch_t op;
        op.op      = ooo_pkg::alu_op_e'($urandom % 8);
        op.src1    = ooo_pkg::arch_reg_t'($urandom % reg_span);
        op.src2    = ooo_pkg::arch_reg_t'($urandom % reg_span);
        op.dst     = ooo_pkg::arch_reg_t'($urandom % reg_span);
        op.imm     = ($urandom % 2) ? $urandom : ($urandom % 64);
        op.use_imm = $urandom % 2;
        return op;
    endfunction

    // holds the op until the DUT takes it
    task automatic send_op(input ooo_pkg::dispatch_t op);
        @(posedge clk);
        dispatch       <= op;
        dispatch_valid <= 1'b1;
        do begin
            @(negedge clk);
        end while (!dispatch_ready);
    endtask

    task automatic idle_cycles(input int n);
        @(posedge clk);
        dispatch_valid <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    task automatic drain;
        @(posedge clk);
        dispatch_valid <= 1'b0;
        while (pending.size() != 0) @(posedge clk);
    endtask

    always @(negedge clk) begin
        if (arst_n) begin
            if (retire_valid) begin
                if (pending.size() == 0) begin
                    abort_run("retire seen with no operation outstanding");
                end else begin
                    expected = pending.pop_front();
                    check_value("retire.dst", retire.dst, expected.dst);
                    check_value("retire.value", retire.value, expected.value);
                    retired++;
                end
            end
            if (dispatch_valid && !dispatch_ready) begin
                stall_seen = 1'b1;
            end
            if (dispatch_valid && dispatch_ready) begin
                model_dispatch(dispatch);
                accepted++;
            end
            if (accepted - retired > `OOO_ROB_DEPTH) begin
                abort_run("more operations in flight than reorder buffer entries");
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCS) @(posedge clk);
        abort_run("timeout: operations did not retire within the expected time");
    end

    initial begin
        ooo_pkg::dispatch_t op;
        void'($urandom(32'h3c60d982));
        clk            = 1'b0;
        arst_n         = 1'b0;
        dispatch       = '0;
        dispatch_valid = 1'b0;
        accepted       = 0;
        retired        = 0;
        stall_seen     = 1'b0;
        for (int r = 0; r < `OOO_ARCH_REGS; r++) begin
            arch_regs[r] = '0;
        end
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;

        repeat (3) begin
            @(negedge clk);
            check_value("retire_valid", retire_valid, 1'b0);
            check_value("dispatch_ready", dispatch_ready, 1'b1);
        end

        // give every register a nonzero value
        for (int r = 0; r < SEED_OPS; r++) begin
            op         = random_op(`OOO_ARCH_REGS);
            op.op      = ooo_pkg::ALU_ADD;
            op.src1    = ooo_pkg::arch_reg_t'(r);
            op.dst     = ooo_pkg::arch_reg_t'(r);
            op.use_imm = 1'b1;
            send_op(op);
        end
        // each opcode, register and immediate forms
        for (int i = 0; i < OPCODE_OPS; i++) begin
            op         = random_op(`OOO_ARCH_REGS);
            op.op      = ooo_pkg::alu_op_e'(i % 8);
            op.use_imm = i / 8;
            send_op(op);
        end
        drain();

        for (int i = 0; i < DENSE_OPS; i++) begin
            send_op(random_op(3));
        end
        drain();

        for (int b = 0; b < BURSTS; b++) begin
            for (int i = 0; i < BURST_LEN; i++) begin
                send_op(random_op(`OOO_ARCH_REGS));
            end
            drain();
        end

        for (int i = 0; i < LONG_OPS; i++) begin
            send_op(random_op(`OOO_ARCH_REGS));
            if ($urandom % 4 == 0) begin
                idle_cycles($urandom % 4 + 1);
            end
        end
        drain();
        // any late retire would show up here
        repeat (10) @(posedge clk);

        if (!stall_seen) begin
            abort_run("dispatch_ready never dropped under back-to-back dispatch");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+logic
logic/ooo_pkg.sv
logic/rename_unit.sv
logic/phys_reg_file.sv
logic/issue_queue.sv
logic/alu_unit.sv
logic/reorder_buffer.sv
logic/ooo_core.sv
verification/ooo_core_tb.sv
